//--- gb_ppu.f
+incdir+hdl
hdl/gb_ppu_pkg.sv
hdl/pixel_fifo_if.sv
hdl/ppu_timing.sv
hdl/ppu_host_port.sv
hdl/bg_fetcher.sv
hdl/bg_pixel_fifo.sv
hdl/gb_ppu.sv
tests/gb_ppu_tb.sv

//--- tests/gb_ppu_tb.sv
`timescale 1ns/1ps

`include "gb_ppu_settings.svh"

module gb_ppu_tb;

  localparam integer LINE  = `DOTS_PER_LINE;
  localparam integer FRAME = `DOTS_PER_LINE * `LINES_PER_FRAME;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [7:0]  rdata;
  logic        vblank_req;
  logic        stat_req;
  logic        pixel_valid;
  logic [7:0]  pixel_x;
  logic [7:0]  pixel_y;
  logic [1:0]  pixel_shade;

  // Copy of VRAM contents as written by the bus
  logic [7:0]  vram_model [0:8191];
  integer      seed = 97;
  integer      errors = 0;
  integer      tick;
  integer      on_tick = 0;
  integer      vblank_count = 0;
  integer      stat_count = 0;
  integer      stat_last = 0;

  gb_ppu gb_ppu_inst (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .rdata       (rdata),
    .vblank_req  (vblank_req),
    .stat_req    (stat_req),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Free running cycle count, position in frame is tick - on_tick
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      tick <= 0;
    end else begin
      tick <= tick + 1;
    end
  end

  // Interrupt pulse counters, sampled mid cycle
  always @(negedge clk) begin
    if (vblank_req) begin
      vblank_count <= vblank_count + 1;
    end
    if (stat_req) begin
      stat_count <= stat_count + 1;
      stat_last  <= tick - on_tick;
    end
  end

  // ==========================================================================
  // Checking and bus helpers
  // ==========================================================================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    begin
      if (actual !== expected) begin
        errors = errors + 1;
        $display("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                 expected);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
      end
    end
  endtask

  task automatic abort_run(input string reason);
    begin
      $display("Error at %0t ns: %s", $time, reason);
      $display("TESTS FAILED");
      $fatal(1, "run aborted");
    end
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    begin
      @(posedge clk);
      addr     <= a;
      wdata    <= d;
      write_en <= 1'b1;
      @(posedge clk);
      write_en <= 1'b0;
    end
  endtask

  // rdata is combinational, sampled at the falling edge
  task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    begin
      @(posedge clk);
      addr    <= a;
      read_en <= 1'b1;
      @(negedge clk);
      d = rdata;
      @(posedge clk);
      read_en <= 1'b0;
    end
  endtask

  task automatic expect_read(input logic [15:0] a, input logic [7:0] expected,
                             input string name);
    logic [7:0] d;
    begin
      bus_read(a, d);
      check_value(name, d, expected);
    end
  endtask

  // Waits for the falling edge of the cycle at frame position pos
  task automatic wait_for_pos(input integer pos);
    integer guard;
    begin
      guard = 0;
      @(negedge clk);
      while ((tick - on_tick) != pos) begin
        guard = guard + 1;
        if (guard > 2 * FRAME) begin
          abort_run("timeout waiting for a dot position");
        end
        @(negedge clk);
      end
    end
  endtask

  // Bus access lands in the cycle at position pos
  task automatic read_at(input integer pos, input logic [15:0] a,
                         input logic [7:0] expected, input string name);
    begin
      wait_for_pos(pos - 1);
      expect_read(a, expected, name);
    end
  endtask

  task automatic write_at(input integer pos, input logic [15:0] a, input logic [7:0] d);
    begin
      wait_for_pos(pos - 1);
      bus_write(a, d);
    end
  endtask

  task automatic mode_at(input integer pos, input logic [1:0] expected);
    logic [7:0] d;
    begin
      wait_for_pos(pos - 1);
      bus_read(`STAT_ADDR, d);
      check_value("STAT mode", d[1:0], expected);
      check_value("STAT bit 7", d[7], 1'b1);
    end
  endtask

  // Dot 0 of line 0 is the cycle right after the enabling write
  task automatic enable_lcd(input logic [7:0] lcdc);
    begin
      bus_write(`LCDC_ADDR, lcdc);
      @(negedge clk);
      on_tick = tick;
    end
  endtask

  task automatic disable_lcd;
    begin
      bus_write(`LCDC_ADDR, 8'h00);
    end
  endtask

  // ==========================================================================
  // Reference background pixel
  // ==========================================================================
  function automatic logic [1:0] ref_shade(input integer x, input integer line,
                                           input logic [7:0] lcdc, input logic [7:0] scx,
                                           input logic [7:0] scy, input logic [7:0] bgp);
    integer     bx;
    integer     by;
    integer     map_idx;
    integer     tile_s;
    integer     tile_idx;
    integer     bit_no;
    logic [7:0] tile_no;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    begin
      // Position in the 256x256 background
      bx = (x + scx) % 256;
      by = (line + scy) % 256;
      map_idx = (lcdc[3] ? 7168 : 6144) + (by / 8) * 32 + bx / 8;
      tile_no = vram_model[map_idx];
      tile_s  = tile_no;
      if (lcdc[4]) begin
        tile_idx = tile_s * 16;
      end else begin
        // Signed tile numbers around 9000h
        if (tile_s >= 128) begin
          tile_s = tile_s - 256;
        end
        tile_idx = 4096 + tile_s * 16;
      end
      lo     = vram_model[tile_idx + 2 * (by % 8)];
      hi     = vram_model[tile_idx + 2 * (by % 8) + 1];
      bit_no = 7 - (bx % 8);
      color  = {hi[bit_no], lo[bit_no]};
      if (!lcdc[0]) begin
        color = 2'd0;
      end
      ref_shade = bgp[2 * color +: 2];
    end
  endfunction

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic registers_readback;
    logic [15:0] regs_list [0:6];
    logic [15:0] a;
    integer      i;
    begin
      regs_list = '{`LCDC_ADDR, `SCY_ADDR, `SCX_ADDR, `LYC_ADDR, `BGP_ADDR, `WY_ADDR,
                    `WX_ADDR};
      @(negedge clk);
      check_value("vblank_req", vblank_req, 1'b0);
      check_value("stat_req", stat_req, 1'b0);
      check_value("pixel_valid", pixel_valid, 1'b0);
      check_value("pixel_x", pixel_x, 8'd0);
      check_value("pixel_y", pixel_y, 8'd0);
      check_value("pixel_shade", pixel_shade, 2'd0);
      for (i = 0; i < 7; i = i + 1) begin
        expect_read(regs_list[i], 8'h00, "register after reset");
      end
      expect_read(`LY_ADDR, 8'h00, "LY after reset");
      // LY and LYC both 0, so coincidence set, mode reads OAM scan
      expect_read(`STAT_ADDR, 8'h86, "STAT after reset");
      // Byte pattern from the low address nibble, LCDC bit 7 stays clear
      for (i = 0; i < 7; i = i + 1) begin
        a = regs_list[i];
        bus_write(a, {a[3:0], ~a[3:0]});
      end
      for (i = 0; i < 7; i = i + 1) begin
        a = regs_list[i];
        expect_read(a, {a[3:0], ~a[3:0]}, "register readback");
      end
      bus_write(`STAT_ADDR, 8'hFF);
      expect_read(`STAT_ADDR, 8'hFA, "STAT writable bits");
      bus_write(`LY_ADDR, 8'h33);
      expect_read(`LY_ADDR, 8'h00, "LY after write");
      // Open bus
      expect_read(`DMA_ADDR, 8'hFF, "DMA register");
      expect_read(16'hFF48, 8'hFF, "OBP0 slot");
      expect_read(16'hFF49, 8'hFF, "OBP1 slot");
      expect_read(16'hFF4C, 8'hFF, "above registers");
      expect_read(16'hFF3F, 8'hFF, "below registers");
      expect_read(16'h0000, 8'hFF, "ROM space");
      expect_read(16'h7FFF, 8'hFF, "below VRAM");
      expect_read(16'hA000, 8'hFF, "above VRAM");
      expect_read(16'hFEA0, 8'hFF, "above OAM");
      expect_read(16'hFDFF, 8'hFF, "below OAM");
      for (i = 0; i < 12; i = i + 1) begin
        bus_write(`REGS_START + i, 8'h00);
      end
    end
  endtask

  task automatic memory_access;
    logic [15:0] a;
    integer      i;
    begin
      // Spread over all of VRAM, last byte too
      for (i = 0; i < 17; i = i + 1) begin
        a = (i == 16) ? `VRAM_END : `VRAM_START + (i * 545) % 8192;
        bus_write(a, a[15:8] ^ a[7:0] ^ 8'hA5);
      end
      for (i = 0; i < 17; i = i + 1) begin
        a = (i == 16) ? `VRAM_END : `VRAM_START + (i * 545) % 8192;
        expect_read(a, a[15:8] ^ a[7:0] ^ 8'hA5, "VRAM readback");
      end
      for (i = 0; i < 17; i = i + 1) begin
        a = (i == 16) ? `OAM_END : `OAM_START + i * 9;
        bus_write(a, a[15:8] ^ a[7:0] ^ 8'h3C);
      end
      for (i = 0; i < 17; i = i + 1) begin
        a = (i == 16) ? `OAM_END : `OAM_START + i * 9;
        expect_read(a, a[15:8] ^ a[7:0] ^ 8'h3C, "OAM readback");
      end
    end
  endtask

  task automatic vram_lockout;
    begin
      bus_write(16'h8123, 8'h3C);
      enable_lcd(8'h91);
      read_at(100, 16'h8123, 8'hFF, "VRAM read in transfer");
      // Dropped
      write_at(120, 16'h8123, 8'hC3);
      read_at(300, 16'h8123, 8'h3C, "VRAM after transfer write");
      // HBlank write goes through
      write_at(LINE + 320, 16'h8123, 8'h5A);
      read_at(LINE + 330, 16'h8123, 8'h5A, "VRAM after HBlank write");
      // OAM open in every mode
      write_at(2 * LINE + 150, 16'hFE10, 8'h77);
      read_at(2 * LINE + 160, 16'hFE10, 8'h77, "OAM in transfer");
      disable_lcd();
    end
  endtask

  task automatic frame_timing;
    integer start_count;
    integer guard;
    begin
      start_count = vblank_count;
      enable_lcd(8'h91);
      read_at(450, `LY_ADDR, 8'd0, "LY line 0");
      read_at(LINE + 2, `LY_ADDR, 8'd1, "LY line 1");
      read_at(2 * LINE + 2, `LY_ADDR, 8'd2, "LY line 2");
      read_at(3 * LINE - 3, `LY_ADDR, 8'd2, "LY end of line 2");
      mode_at(3 * LINE + 10, gb_ppu_pkg::MODE_OAM_SCAN);
      mode_at(3 * LINE + 100, gb_ppu_pkg::MODE_TRANSFER);
      mode_at(3 * LINE + 300, gb_ppu_pkg::MODE_HBLANK);
      guard = 0;
      @(negedge clk);
      while (!vblank_req) begin
        guard = guard + 1;
        if (guard > FRAME) begin
          abort_run("timeout waiting for vblank_req");
        end
        @(negedge clk);
      end
      check_value("vblank_req position", tick - on_tick, 144 * LINE);
      read_at(144 * LINE + 3, `LY_ADDR, 8'd144, "LY first VBlank line");
      mode_at(144 * LINE + 20, gb_ppu_pkg::MODE_VBLANK);
      read_at(153 * LINE + 3, `LY_ADDR, 8'd153, "LY last line");
      read_at(154 * LINE + 3, `LY_ADDR, 8'd0, "LY after wrap");
      check_value("vblank_req pulses", vblank_count - start_count, 1);
      disable_lcd();
    end
  endtask

  task automatic stat_interrupts;
    integer start_count;
    begin
      // LYC source only
      bus_write(`LYC_ADDR, 8'd5);
      bus_write(`STAT_ADDR, 8'h40);
      start_count = stat_count;
      enable_lcd(8'h91);
      wait_for_pos(6 * LINE);
      check_value("stat_req LYC pulses", stat_count - start_count, 1);
      check_value("stat_req LYC position", stat_last, 5 * LINE + 1);
      disable_lcd();
      // HBlank source only, entry at dot 252
      bus_write(`STAT_ADDR, 8'h08);
      start_count = stat_count;
      enable_lcd(8'h91);
      wait_for_pos(4 * LINE);
      check_value("stat_req HBlank pulses", stat_count - start_count, 4);
      check_value("stat_req HBlank position", stat_last, 3 * LINE + 253);
      disable_lcd();
      // All sources off
      bus_write(`STAT_ADDR, 8'h00);
      start_count = stat_count;
      enable_lcd(8'h91);
      wait_for_pos(7 * LINE);
      check_value("stat_req with sources off", stat_count - start_count, 0);
      disable_lcd();
      bus_write(`LYC_ADDR, 8'd0);
    end
  endtask

  task automatic fill_vram;
    integer     i;
    logic [31:0] r;
    begin
      for (i = 0; i < 8192; i = i + 1) begin
        r = $random(seed);
        vram_model[i] = r[7:0];
        bus_write(`VRAM_START + i, r[7:0]);
      end
    end
  endtask

  // Collects one whole line of output and compares each pixel
  task automatic render_line(input logic [7:0] lcdc, input logic [7:0] scx,
                             input logic [7:0] scy, input logic [7:0] bgp,
                             input integer line);
    integer d;
    integer count;
    begin
      bus_write(`SCX_ADDR, scx);
      bus_write(`SCY_ADDR, scy);
      bus_write(`BGP_ADDR, bgp);
      enable_lcd(lcdc);
      count = 0;
      wait_for_pos(line * LINE);
      for (d = 0; d < LINE; d = d + 1) begin
        if (pixel_valid) begin
          if (d < `MODE2_LEN || d >= `MODE2_LEN + `MODE3_LEN) begin
            abort_run("pixel came out outside pixel transfer");
          end
          check_value("pixel_x", pixel_x, count);
          check_value("pixel_y", pixel_y, line);
          check_value("pixel_shade", pixel_shade,
                      ref_shade(count, line, lcdc, scx, scy, bgp));
          count = count + 1;
        end
        @(negedge clk);
      end
      check_value("pixels per line", count, `SCREEN_WIDTH);
      disable_lcd();
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    reset    = 1'b1;
    addr     = 16'h0000;
    wdata    = 8'h00;
    write_en = 1'b0;
    read_en  = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    registers_readback();
    memory_access();
    vram_lockout();
    frame_timing();
    stat_interrupts();

    fill_vram();
    // Map at 9C00h, unsigned tiles
    render_line(8'h99, 8'h2D, 8'h13, 8'hE4, 3);
    // Map at 9800h, signed tiles, scroll wraps around
    render_line(8'h81, 8'hF7, 8'hC6, 8'hE4, 77);
    // Background off, every pixel is color 0
    render_line(8'h90, 8'h0A, 8'h31, 8'h1B, 10);

    if (errors == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- hdl/gb_ppu.sv
`timescale 1ns/1ps

module gb_ppu (
  input  logic        clk,
  input  logic        reset,
  // CPU bus
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  output logic [7:0]  rdata,
  // Interrupt requests
  output logic        vblank_req,
  output logic        stat_req,
  // Pixel stream
  output logic        pixel_valid,
  output logic [7:0]  pixel_x,
  output logic [7:0]  pixel_y,
  output logic [1:0]  pixel_shade
);

  gb_ppu_pkg::ppu_regs_t regs;
  gb_ppu_pkg::ppu_mode_t mode;
  logic [7:0]            ly;
  logic                  coincidence;
  logic [12:0]           fetch_addr;
  logic [7:0]            fetch_data;

  // Fetcher to FIFO rows
  pixel_fifo_if fifo_bus ();

  // ========================================================================
  // Timing, host port and background pipeline
  // ========================================================================
  ppu_timing timing_inst (
    .clk         (clk),
    .reset       (reset),
    .regs        (regs),
    .mode        (mode),
    .ly          (ly),
    .dot         (),
    .coincidence (coincidence),
    .vblank_req  (vblank_req),
    .stat_req    (stat_req)
  );

  ppu_host_port host_port_inst (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .rdata       (rdata),
    .mode        (mode),
    .ly          (ly),
    .coincidence (coincidence),
    .regs        (regs),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data)
  );

  bg_fetcher fetcher_inst (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .regs       (regs),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .fifo       (fifo_bus.fetcher)
  );

  bg_pixel_fifo pixel_fifo_inst (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .ly          (ly),
    .regs        (regs),
    .fifo        (fifo_bus.fifo),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

endmodule

//--- hdl/bg_pixel_fifo.sv
`timescale 1ns/1ps

`include "gb_ppu_settings.svh"

module bg_pixel_fifo (
  input  logic                  clk,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]            ly,
  input  gb_ppu_pkg::ppu_regs_t regs,
  pixel_fifo_if.fifo            fifo,
  output logic                  pixel_valid,
  output logic [7:0]            pixel_x,
  output logic [7:0]            pixel_y,
  output logic [1:0]            pixel_shade
);

  // Head of queue in bits 31:30
  logic [31:0]           shifter;
  logic [31:0]           shifted;
  logic [4:0]            count;
  logic [4:0]            kept;
  logic [2:0]            discard;
  logic [7:0]            x_count;
  logic [1:0]            color;
  gb_ppu_pkg::ppu_mode_t mode_prev;
  logic                  in_transfer;
  logic                  pop;

  assign in_transfer = (mode == gb_ppu_pkg::MODE_TRANSFER);
  // First dot of each pixel transfer
  assign fifo.clear  = in_transfer && (mode_prev != gb_ppu_pkg::MODE_TRANSFER);
  assign fifo.room   = (count <= 5'd8);

  // One pixel per dot once anything is queued
  assign pop     = in_transfer && !fifo.clear && (count != 5'd0);
  assign shifted = pop ? (shifter << 2) : shifter;
  assign kept    = count - {4'd0, pop};

  // ========================================================================
  // Queue and line counters
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shifter   <= 32'd0;
      count     <= 5'd0;
      discard   <= 3'd0;
      x_count   <= 8'd0;
      mode_prev <= gb_ppu_pkg::MODE_OAM_SCAN;
    end else begin
      mode_prev <= mode;
      if (fifo.clear) begin
        shifter <= 32'd0;
        count   <= 5'd0;
        // Fine scroll drops leading pixels
        discard <= regs.scx[2:0];
        x_count <= 8'd0;
      end else begin
        // New row lands right behind what is left
        if (fifo.push) begin
          shifter <= shifted | ({fifo.row, 16'd0} >> {kept, 1'b0});
          count   <= kept + 5'd8;
        end else begin
          shifter <= shifted;
          count   <= kept;
        end
        if (pop) begin
          if (discard != 3'd0) begin
            discard <= discard - 3'd1;
          end else if (x_count < 8'(`SCREEN_WIDTH)) begin
            x_count <= x_count + 8'd1;
          end
        end
      end
    end
  end

  // ========================================================================
  // Palette and pixel output
  // ========================================================================
  // LCDC bit 0 off blanks background to color 0
  assign color = regs.lcdc[0] ? shifter[31:30] : 2'b00;

  assign pixel_valid = pop && (discard == 3'd0) && (x_count < 8'(`SCREEN_WIDTH));
  assign pixel_shade = regs.bgp[{color, 1'b0} +: 2];
  assign pixel_x     = x_count;
  assign pixel_y     = ly;

endmodule

//--- hdl/bg_fetcher.sv
`timescale 1ns/1ps

`include "gb_ppu_settings.svh"

module bg_fetcher (
  input  logic                  clk,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]            ly,
  input  gb_ppu_pkg::ppu_regs_t regs,
  output logic [12:0]           fetch_addr,
  input  logic [7:0]            fetch_data,
  pixel_fifo_if.fetcher         fifo
);

  gb_ppu_pkg::fetch_state_t state;
  logic [4:0]               tile_col;
  logic [7:0]               tile_no;
  logic [7:0]               data_lo;
  logic [7:0]               data_hi;
  logic [7:0]               map_y;
  logic [15:0]              map_addr;
  logic [15:0]              tile_base;
  logic [15:0]              data_addr;
  logic                     active;

  // Fetch only in pixel transfer, not on the restart cycle
  assign active = (mode == gb_ppu_pkg::MODE_TRANSFER) && !fifo.clear;

  // ========================================================================
  // VRAM addressing
  // ========================================================================
  // Background row in the 256x256 map
  assign map_y = ly + regs.scy;

  // 32x32 map, LCDC bit 3 picks which one
  assign map_addr = (regs.lcdc[3] ? 16'h9C00 : 16'h9800) + {6'd0, map_y[7:3], tile_col};

  // 16 bytes per tile
  always_comb begin
    if (regs.lcdc[4]) begin
      tile_base = 16'h8000 + {4'd0, tile_no, 4'd0};
    end else begin
      // Signed tile number around 9000h
      tile_base = 16'h9000 + {{4{tile_no[7]}}, tile_no, 4'd0};
    end
  end

  // Two bytes per fine row, high byte second
  assign data_addr = tile_base + {12'd0, map_y[2:0], (state == gb_ppu_pkg::FETCH_DATA_HI)};

  assign fetch_addr = (state == gb_ppu_pkg::FETCH_TILE_NO) ? 13'(map_addr - `VRAM_START)
                                                           : 13'(data_addr - `VRAM_START);

  // ========================================================================
  // Fetch state machine
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= gb_ppu_pkg::FETCH_TILE_NO;
      tile_col <= 5'd0;
    end else if (fifo.clear) begin
      // Coarse scroll picks the first column
      state    <= gb_ppu_pkg::FETCH_TILE_NO;
      tile_col <= regs.scx[7:3];
    end else if (mode != gb_ppu_pkg::MODE_TRANSFER) begin
      state <= gb_ppu_pkg::FETCH_TILE_NO;
    end else begin
      case (state)
        gb_ppu_pkg::FETCH_TILE_NO: state <= gb_ppu_pkg::FETCH_DATA_LO;
        gb_ppu_pkg::FETCH_DATA_LO: state <= gb_ppu_pkg::FETCH_DATA_HI;
        gb_ppu_pkg::FETCH_DATA_HI: state <= gb_ppu_pkg::FETCH_PUSH;
        gb_ppu_pkg::FETCH_PUSH: begin
          // Wait for space, column wraps at 32
          if (fifo.room) begin
            state    <= gb_ppu_pkg::FETCH_TILE_NO;
            tile_col <= tile_col + 5'd1;
          end
        end
        default: state <= gb_ppu_pkg::FETCH_TILE_NO;
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    if (active) begin
      case (state)
        gb_ppu_pkg::FETCH_TILE_NO: tile_no <= fetch_data;
        gb_ppu_pkg::FETCH_DATA_LO: data_lo <= fetch_data;
        gb_ppu_pkg::FETCH_DATA_HI: data_hi <= fetch_data;
        default: ;
      endcase
    end
  end

  // Bit 7 of each plane is the leftmost pixel
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      fifo.row[2*i +: 2] = {data_hi[i], data_lo[i]};
    end
  end

  assign fifo.push = active && (state == gb_ppu_pkg::FETCH_PUSH) && fifo.room;

endmodule

//--- hdl/ppu_host_port.sv
`timescale 1ns/1ps

`include "gb_ppu_settings.svh"

module ppu_host_port (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [15:0]           addr,
  input  logic [7:0]            wdata,
  input  logic                  write_en,
  input  logic                  read_en,
  output logic [7:0]            rdata,
  input  gb_ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]            ly,
  input  logic                  coincidence,
  output gb_ppu_pkg::ppu_regs_t regs,
  input  logic [12:0]           fetch_addr,
  output logic [7:0]            fetch_data
);

  // 8 KB video RAM and 160-byte sprite table
  logic [7:0]  vram [0:`VRAM_END - `VRAM_START];
  logic [7:0]  oam  [0:`OAM_END - `OAM_START];

  logic        vram_sel;
  logic        oam_sel;
  logic        regs_sel;
  logic        transfer;
  logic [12:0] vram_idx;
  logic [7:0]  oam_idx;

  // ========================================================================
  // Address decode
  // ========================================================================
  assign vram_sel = addr inside {[`VRAM_START : `VRAM_END]};
  assign oam_sel  = addr inside {[`OAM_START : `OAM_END]};
  assign regs_sel = addr inside {[`REGS_START : `REGS_END]};
  assign vram_idx = 13'(addr - `VRAM_START);
  assign oam_idx  = 8'(addr - `OAM_START);

  // CPU locked out of VRAM while pixels are fetched
  assign transfer = (mode == gb_ppu_pkg::MODE_TRANSFER);

  // ========================================================================
  // Writes
  // ========================================================================
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && !transfer) begin
      vram[vram_idx] <= wdata;
    end
    if (write_en && oam_sel) begin
      oam[oam_idx] <= wdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (write_en && regs_sel) begin
      case (addr)
        `LCDC_ADDR: regs.lcdc    <= wdata;
        // Only interrupt enables are writable
        `STAT_ADDR: regs.stat_en <= wdata[6:3];
        `SCY_ADDR:  regs.scy     <= wdata;
        `SCX_ADDR:  regs.scx     <= wdata;
        `LYC_ADDR:  regs.lyc     <= wdata;
        `BGP_ADDR:  regs.bgp     <= wdata;
        `WY_ADDR:   regs.wy      <= wdata;
        `WX_ADDR:   regs.wx      <= wdata;
        // LY is read only, DMA not implemented
        default: ;
      endcase
    end
  end

  // ========================================================================
  // Reads, same cycle as read_en
  // ========================================================================
  always_comb begin
    // Open bus
    rdata = 8'hFF;
    if (read_en) begin
      if (vram_sel) begin
        if (!transfer) begin
          rdata = vram[vram_idx];
        end
      end else if (oam_sel) begin
        rdata = oam[oam_idx];
      end else if (regs_sel) begin
        case (addr)
          `LCDC_ADDR: rdata = regs.lcdc;
          `STAT_ADDR: rdata = {1'b1, regs.stat_en, coincidence, mode};
          `SCY_ADDR:  rdata = regs.scy;
          `SCX_ADDR:  rdata = regs.scx;
          `LY_ADDR:   rdata = ly;
          `LYC_ADDR:  rdata = regs.lyc;
          `DMA_ADDR:  rdata = 8'hFF;
          `BGP_ADDR:  rdata = regs.bgp;
          `WY_ADDR:   rdata = regs.wy;
          `WX_ADDR:   rdata = regs.wx;
          // OBP0 and OBP1 slots
          default:    rdata = 8'hFF;
        endcase
      end
    end
  end

  // Fetcher port, never blocked
  assign fetch_data = vram[fetch_addr];

endmodule

//--- hdl/ppu_timing.sv
`timescale 1ns/1ps

`include "gb_ppu_settings.svh"

module ppu_timing (
  input  logic                  clk,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_regs_t regs,
  output gb_ppu_pkg::ppu_mode_t mode,
  output logic [7:0]            ly,
  output logic [8:0]            dot,
  output logic                  coincidence,
  output logic                  vblank_req,
  output logic                  stat_req
);

  logic                  lcd_on;
  logic                  end_of_line;
  logic [7:0]            ly_prev;
  gb_ppu_pkg::ppu_mode_t mode_prev;
  logic                  lyc_event;
  logic                  mode_event;

  assign lcd_on      = regs.lcdc[7];
  assign end_of_line = (dot == 9'(`DOTS_PER_LINE - 1));

  // ========================================================================
  // Dot and line counters
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= 9'd0;
      ly         <= 8'd0;
      vblank_req <= 1'b0;
    end else begin
      // Entry to line 144 only
      vblank_req <= lcd_on && end_of_line && (ly == 8'(`SCREEN_HEIGHT - 1));
      if (!lcd_on) begin
        // LCD off holds the counters at top of frame
        dot <= 9'd0;
        ly  <= 8'd0;
      end else if (end_of_line) begin
        dot <= 9'd0;
        ly  <= (ly == 8'(`LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
      end else begin
        dot <= dot + 9'd1;
      end
    end
  end

  // Mode straight from position in frame
  always_comb begin
    if (ly >= 8'(`SCREEN_HEIGHT)) begin
      mode = gb_ppu_pkg::MODE_VBLANK;
    end else if (dot < 9'(`MODE2_LEN)) begin
      mode = gb_ppu_pkg::MODE_OAM_SCAN;
    end else if (dot < 9'(`MODE2_LEN + `MODE3_LEN)) begin
      mode = gb_ppu_pkg::MODE_TRANSFER;
    end else begin
      mode = gb_ppu_pkg::MODE_HBLANK;
    end
  end

  // ========================================================================
  // STAT interrupt sources
  // ========================================================================
  // LY just changed onto LYC
  assign lyc_event = regs.stat_en[3] && (ly != ly_prev) && (ly == regs.lyc);

  // New mode with its enable bit set
  always_comb begin
    mode_event = 1'b0;
    if (mode != mode_prev) begin
      case (mode)
        gb_ppu_pkg::MODE_OAM_SCAN: mode_event = regs.stat_en[2];
        gb_ppu_pkg::MODE_VBLANK:   mode_event = regs.stat_en[1];
        gb_ppu_pkg::MODE_HBLANK:   mode_event = regs.stat_en[0];
        default:                   mode_event = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev     <= 8'd0;
      mode_prev   <= gb_ppu_pkg::MODE_OAM_SCAN;
      coincidence <= 1'b0;
      stat_req    <= 1'b0;
    end else begin
      ly_prev     <= ly;
      mode_prev   <= mode;
      coincidence <= (ly == regs.lyc);
      // One pulse for a LYC match, a mode entry or both
      stat_req    <= lyc_event || mode_event;
    end
  end

endmodule

//--- hdl/pixel_fifo_if.sv
`timescale 1ns/1ps

interface pixel_fifo_if;

  // One row of 8 color indices, leftmost pixel in bits 15:14
  logic [15:0] row;
  // Single-cycle push strobe
  logic push;
  // FIFO holds 8 or fewer entries
  logic room;
  // Start of pixel transfer, restarts the fetcher
  logic clear;

  modport fetcher (
    output push,
    output row,
    input  room,
    input  clear
  );

  modport fifo (
    input  push,
    input  row,
    output room,
    output clear
  );

endinterface

//--- hdl/gb_ppu_pkg.sv
package gb_ppu_pkg;

  // STAT mode field encoding
  typedef enum logic [1:0] {
    MODE_HBLANK   = 2'd0,
    MODE_VBLANK   = 2'd1,
    MODE_OAM_SCAN = 2'd2,
    MODE_TRANSFER = 2'd3
  } ppu_mode_t;

  // Background fetcher steps
  typedef enum logic [1:0] {
    FETCH_TILE_NO = 2'd0,
    FETCH_DATA_LO = 2'd1,
    FETCH_DATA_HI = 2'd2,
    FETCH_PUSH    = 2'd3
  } fetch_state_t;

  // Writable LCD register bytes
  // stat_en[3] LYC, [2] OAM scan, [1] VBlank, [0] HBlank
  typedef struct packed {
    logic [7:0] lcdc;
    logic [3:0] stat_en;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [7:0] wy;
    logic [7:0] wx;
  } ppu_regs_t;

endpackage

//--- hdl/gb_ppu_settings.svh
`ifndef GB_PPU_SETTINGS_SVH
`define GB_PPU_SETTINGS_SVH

// ==========================================================================
// Line and frame timing
// ==========================================================================
`define DOTS_PER_LINE   456
`define LINES_PER_FRAME 154
`define SCREEN_HEIGHT   144
`define SCREEN_WIDTH    160
`define MODE2_LEN       80
`define MODE3_LEN       172

// ==========================================================================
// CPU address map
// ==========================================================================
`define VRAM_START 16'h8000
`define VRAM_END   16'h9FFF
`define OAM_START  16'hFE00
`define OAM_END    16'hFE9F
`define REGS_START 16'hFF40
`define REGS_END   16'hFF4B

// LCD registers
`define LCDC_ADDR 16'hFF40
`define STAT_ADDR 16'hFF41
`define SCY_ADDR  16'hFF42
`define SCX_ADDR  16'hFF43
`define LY_ADDR   16'hFF44
`define LYC_ADDR  16'hFF45
`define DMA_ADDR  16'hFF46
`define BGP_ADDR  16'hFF47
`define WY_ADDR   16'hFF4A
`define WX_ADDR   16'hFF4B

`endif
